// File: Makefile
# Verilator flow for the SIMD ALU testbench

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= simd_alu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
# Let assertion errors reach the testbench so it can report them
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+rtl
rtl/simd_alu_pkg.sv
rtl/simd_adder.sv
rtl/simd_compare.sv
rtl/simd_shifter.sv
rtl/simd_alu.sv
tb/simd_alu_chk.sv
tb/simd_alu_tb.sv

// File: rtl/simd_adder.sv
`timescale 1ns/100ps
`include "simd_alu_cfg.svh"

module simd_adder (
  input  simd_alu_pkg::vew_e      vew_i,
  input  simd_alu_pkg::elem_t     opa_i,
  input  simd_alu_pkg::elem_t     opb_i,
  input  simd_alu_pkg::add_mode_e mode_i,
  input  logic                    sat_i,
  output simd_alu_pkg::elem_t     sum_o,
  output simd_alu_pkg::strb_t     sat_o
);
  import simd_alu_pkg::*;

  strb_t first;
  strb_t last;
  strb_t ovf;
  elem_t x;
  elem_t y;
  elem_t raw;
  logic  cin;

  assign first = elem_first(vew_i);
  assign last  = {1'b1, first[`SIMD_ALU_NB-1:1]};

  // Subtraction as x + ~y + 1
  always_comb begin
    unique case (mode_i)
      AM_SUB: begin
        x   = opb_i;
        y   = ~opa_i;
        cin = 1'b1;
      end
      AM_RSUB: begin
        x   = opa_i;
        y   = ~opb_i;
        cin = 1'b1;
      end
      default: begin
        x   = opb_i;
        y   = opa_i;
        cin = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // Byte-sliced carry chain, cut at element starts
  //////////////////////////////

  always_comb begin
    logic [8:0] bsum;
    logic       carry;
    carry = 1'b0;
    for (int i = 0; i < `SIMD_ALU_NB; i++) begin
      bsum = {1'b0, x[i*8 +: 8]} + {1'b0, y[i*8 +: 8]} + {8'd0, (first[i] ? cin : carry)};
      raw[i*8 +: 8] = bsum[7:0];
      carry  = bsum[8];
      // A borrow shows up as a missing carry
      ovf[i] = bsum[8] ^ cin;
    end
  end

  // Carry-out of the top byte decides the whole element
  always_comb begin
    logic flag;
    flag = 1'b0;
    for (int i = `SIMD_ALU_NB-1; i >= 0; i--) begin
      if (last[i]) begin
        flag = ovf[i];
      end
      sat_o[i] = sat_i & flag;
      sum_o[i*8 +: 8] = (sat_i & flag) ? {8{mode_i == AM_ADD}} : raw[i*8 +: 8];
    end
  end

endmodule

// File: rtl/simd_alu.sv
`timescale 1ns/100ps
`include "simd_alu_cfg.svh"

module simd_alu (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   valid_i,
  input  simd_alu_pkg::alu_req_t req_i,
  output logic                   valid_o,
  output simd_alu_pkg::alu_rsp_t rsp_o
);
  import simd_alu_pkg::*;

  add_mode_e  add_mode;
  logic       add_sat;
  shf_mode_e  shf_mode;
  logic       cmp_signed;
  logic       cmp_max;
  elem_t      sum;
  elem_t      minmax;
  elem_t      shifted;
  elem_t      cmp_res;
  strb_t      sat_flags;
  strb_t      first;
  strb_t      cmp_bit;
  cmp_flags_t flags;
  alu_rsp_t   rsp_d;
  alu_rsp_t   rsp_q;
  logic       valid_q;

  //////////////////////////////
  // Operation decode
  //////////////////////////////

  always_comb begin
    add_mode   = AM_ADD;
    add_sat    = 1'b0;
    shf_mode   = SM_SLL;
    cmp_signed = 1'b0;
    cmp_max    = 1'b0;
    case (req_i.op)
      OP_SUB:  add_mode = AM_SUB;
      OP_RSUB: add_mode = AM_RSUB;
      OP_SADDU: add_sat = 1'b1;
      OP_SSUBU: begin
        add_mode = AM_SUB;
        add_sat  = 1'b1;
      end
      OP_MIN, OP_SLT, OP_SLE: cmp_signed = 1'b1;
      OP_MAX: begin
        cmp_signed = 1'b1;
        cmp_max    = 1'b1;
      end
      OP_MAXU: cmp_max  = 1'b1;
      OP_SRL:  shf_mode = SM_SRL;
      OP_SRA:  shf_mode = SM_SRA;
      default: ;
    endcase
  end

  simd_adder u_adder (
    .vew_i  (req_i.vew),
    .opa_i  (req_i.opa),
    .opb_i  (req_i.opb),
    .mode_i (add_mode),
    .sat_i  (add_sat),
    .sum_o  (sum),
    .sat_o  (sat_flags)
  );

  simd_compare u_compare (
    .vew_i    (req_i.vew),
    .opa_i    (req_i.opa),
    .opb_i    (req_i.opb),
    .signed_i (cmp_signed),
    .max_i    (cmp_max),
    .flags_o  (flags),
    .minmax_o (minmax)
  );

  simd_shifter u_shifter (
    .vew_i   (req_i.vew),
    .opa_i   (req_i.opa),
    .opb_i   (req_i.opb),
    .mode_i  (shf_mode),
    .shift_o (shifted)
  );

  // Compare result as element value 1 or 0
  assign first = elem_first(req_i.vew);

  always_comb begin
    case (req_i.op)
      OP_SEQ:          cmp_bit = flags.equal;
      OP_SNE:          cmp_bit = ~flags.equal;
      OP_SLT, OP_SLTU: cmp_bit = flags.less;
      default:         cmp_bit = flags.less | flags.equal;
    endcase
    for (int i = 0; i < `SIMD_ALU_NB; i++) begin
      cmp_res[i*8 +: 8] = {7'd0, cmp_bit[i] & first[i]};
    end
  end

  //////////////////////////////
  // Result select and output stage
  //////////////////////////////

  always_comb begin
    rsp_d = '0;
    case (req_i.op)
      OP_AND: rsp_d.res = req_i.opa & req_i.opb;
      OP_OR:  rsp_d.res = req_i.opa | req_i.opb;
      OP_XOR: rsp_d.res = req_i.opa ^ req_i.opb;
      OP_ADD, OP_SUB, OP_RSUB: rsp_d.res = sum;
      OP_SADDU, OP_SSUBU: begin
        rsp_d.res = sum;
        rsp_d.sat = sat_flags;
      end
      OP_MIN, OP_MINU, OP_MAX, OP_MAXU: rsp_d.res = minmax;
      OP_SEQ, OP_SNE, OP_SLT, OP_SLTU, OP_SLE, OP_SLEU: rsp_d.res = cmp_res;
      OP_SLL, OP_SRL, OP_SRA: rsp_d.res = shifted;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      rsp_q   <= '0;
    end else begin
      valid_q <= valid_i;
      rsp_q   <= valid_i ? rsp_d : '0;
    end
  end

  assign valid_o = valid_q;
  assign rsp_o   = rsp_q;

endmodule

// File: rtl/simd_alu_cfg.svh
`ifndef SIMD_ALU_CFG_SVH
`define SIMD_ALU_CFG_SVH

// Datapath geometry
`define SIMD_ALU_DW 64
`define SIMD_ALU_NB 8

// Elements per word for each element width
`define SIMD_ALU_LANES8  8
`define SIMD_ALU_LANES16 4
`define SIMD_ALU_LANES32 2
`define SIMD_ALU_LANES64 1

`endif

// File: rtl/simd_alu_pkg.sv
`include "simd_alu_cfg.svh"

package simd_alu_pkg;

  typedef enum logic [1:0] {
    EW8, EW16, EW32, EW64
  } vew_e;

  typedef enum logic [4:0] {
    OP_AND, OP_OR, OP_XOR,
    OP_ADD, OP_SUB, OP_RSUB, OP_SADDU, OP_SSUBU,
    OP_MIN, OP_MINU, OP_MAX, OP_MAXU,
    OP_SEQ, OP_SNE, OP_SLT, OP_SLTU, OP_SLE, OP_SLEU,
    OP_SLL, OP_SRL, OP_SRA
  } alu_op_e;

  // Adder modes: b+a, b-a, a-b
  typedef enum logic [1:0] {
    AM_ADD, AM_SUB, AM_RSUB
  } add_mode_e;

  typedef enum logic [1:0] {
    SM_SLL, SM_SRL, SM_SRA
  } shf_mode_e;

  typedef logic [`SIMD_ALU_DW-1:0] elem_t;
  typedef logic [`SIMD_ALU_NB-1:0] strb_t;

  typedef struct packed {
    alu_op_e op;
    vew_e    vew;
    elem_t   opa;
    elem_t   opb;
  } alu_req_t;

  typedef struct packed {
    elem_t res;
    strb_t sat;
  } alu_rsp_t;

  // Only the lowest byte bit of each element carries a result
  typedef struct packed {
    strb_t less;
    strb_t equal;
  } cmp_flags_t;

  // Bytes that start an element
  function automatic strb_t elem_first(vew_e ew);
    case (ew)
      EW8:     return 8'hff;
      EW16:    return 8'h55;
      EW32:    return 8'h11;
      default: return 8'h01;
    endcase
  endfunction

endpackage

// File: rtl/simd_compare.sv
`timescale 1ns/100ps
`include "simd_alu_cfg.svh"

module simd_compare (
  input  simd_alu_pkg::vew_e       vew_i,
  input  simd_alu_pkg::elem_t      opa_i,
  input  simd_alu_pkg::elem_t      opb_i,
  input  logic                     signed_i,
  input  logic                     max_i,
  output simd_alu_pkg::cmp_flags_t flags_o,
  output simd_alu_pkg::elem_t      minmax_o
);
  import simd_alu_pkg::*;

  strb_t less;
  strb_t equal;

  // less means b < a, sign bit extended only for signed order
  always_comb begin
    less     = '0;
    equal    = '0;
    minmax_o = '0;
    unique case (vew_i)
      EW8: for (int k = 0; k < `SIMD_ALU_LANES8; k++) begin
        less[k]  = $signed({signed_i & opb_i[k*8+7], opb_i[k*8 +: 8]}) <
                   $signed({signed_i & opa_i[k*8+7], opa_i[k*8 +: 8]});
        equal[k] = opa_i[k*8 +: 8] == opb_i[k*8 +: 8];
        minmax_o[k*8 +: 8] = (less[k] ^ max_i) ? opb_i[k*8 +: 8] : opa_i[k*8 +: 8];
      end
      EW16: for (int k = 0; k < `SIMD_ALU_LANES16; k++) begin
        less[2*k]  = $signed({signed_i & opb_i[k*16+15], opb_i[k*16 +: 16]}) <
                     $signed({signed_i & opa_i[k*16+15], opa_i[k*16 +: 16]});
        equal[2*k] = opa_i[k*16 +: 16] == opb_i[k*16 +: 16];
        minmax_o[k*16 +: 16] =
          (less[2*k] ^ max_i) ? opb_i[k*16 +: 16] : opa_i[k*16 +: 16];
      end
      EW32: for (int k = 0; k < `SIMD_ALU_LANES32; k++) begin
        less[4*k]  = $signed({signed_i & opb_i[k*32+31], opb_i[k*32 +: 32]}) <
                     $signed({signed_i & opa_i[k*32+31], opa_i[k*32 +: 32]});
        equal[4*k] = opa_i[k*32 +: 32] == opb_i[k*32 +: 32];
        minmax_o[k*32 +: 32] =
          (less[4*k] ^ max_i) ? opb_i[k*32 +: 32] : opa_i[k*32 +: 32];
      end
      default: for (int k = 0; k < `SIMD_ALU_LANES64; k++) begin
        less[8*k]  = $signed({signed_i & opb_i[k*64+63], opb_i[k*64 +: 64]}) <
                     $signed({signed_i & opa_i[k*64+63], opa_i[k*64 +: 64]});
        equal[8*k] = opa_i[k*64 +: 64] == opb_i[k*64 +: 64];
        minmax_o[k*64 +: 64] =
          (less[8*k] ^ max_i) ? opb_i[k*64 +: 64] : opa_i[k*64 +: 64];
      end
    endcase
  end

  assign flags_o = '{less: less, equal: equal};

endmodule

// File: rtl/simd_shifter.sv
`timescale 1ns/100ps
`include "simd_alu_cfg.svh"

module simd_shifter (
  input  simd_alu_pkg::vew_e      vew_i,
  input  simd_alu_pkg::elem_t     opa_i,
  input  simd_alu_pkg::elem_t     opb_i,
  input  simd_alu_pkg::shf_mode_e mode_i,
  output simd_alu_pkg::elem_t     shift_o
);
  import simd_alu_pkg::*;

  // Right shifts go through one extra fill bit on top
  always_comb begin
    logic arith;
    arith   = (mode_i == SM_SRA);
    shift_o = '0;
    unique case (vew_i)
      EW8: for (int k = 0; k < `SIMD_ALU_LANES8; k++) begin
        if (mode_i == SM_SLL) begin
          shift_o[k*8 +: 8] = opb_i[k*8 +: 8] << opa_i[k*8 +: 3];
        end else begin
          shift_o[k*8 +: 8] =
            8'($signed({arith & opb_i[k*8+7], opb_i[k*8 +: 8]}) >>> opa_i[k*8 +: 3]);
        end
      end
      EW16: for (int k = 0; k < `SIMD_ALU_LANES16; k++) begin
        if (mode_i == SM_SLL) begin
          shift_o[k*16 +: 16] = opb_i[k*16 +: 16] << opa_i[k*16 +: 4];
        end else begin
          shift_o[k*16 +: 16] =
            16'($signed({arith & opb_i[k*16+15], opb_i[k*16 +: 16]}) >>> opa_i[k*16 +: 4]);
        end
      end
      EW32: for (int k = 0; k < `SIMD_ALU_LANES32; k++) begin
        if (mode_i == SM_SLL) begin
          shift_o[k*32 +: 32] = opb_i[k*32 +: 32] << opa_i[k*32 +: 5];
        end else begin
          shift_o[k*32 +: 32] =
            32'($signed({arith & opb_i[k*32+31], opb_i[k*32 +: 32]}) >>> opa_i[k*32 +: 5]);
        end
      end
      default: for (int k = 0; k < `SIMD_ALU_LANES64; k++) begin
        if (mode_i == SM_SLL) begin
          shift_o[k*64 +: 64] = opb_i[k*64 +: 64] << opa_i[k*64 +: 6];
        end else begin
          shift_o[k*64 +: 64] =
            64'($signed({arith & opb_i[k*64+63], opb_i[k*64 +: 64]}) >>> opa_i[k*64 +: 6]);
        end
      end
    endcase
  end

endmodule

// File: tb/simd_alu_chk.sv
`timescale 1ns/100ps
`include "simd_alu_cfg.svh"

module simd_alu_chk (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input logic                   valid_i,
  input simd_alu_pkg::alu_req_t req_i,
  input logic                   valid_o,
  input simd_alu_pkg::alu_rsp_t rsp_o
);
  import simd_alu_pkg::*;

  bit       bad_rst = 1'b0;
  bit       bad_idle = 1'b0;
  bit       bad_valid = 1'b0;
  bit       bad_data = 1'b0;
  bit       bad_sat = 1'b0;
  bit       bad_nosat = 1'b0;
  logic     failed;
  logic     vld_q;
  alu_op_e  op_q;
  alu_rsp_t exp_q;

  //////////////////////////////
  // Reference model per element
  //////////////////////////////

  function automatic alu_rsp_t exp_rsp(alu_req_t r);
    alu_rsp_t    o;
    int          w;
    int          sh;
    logic [63:0] m;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] e;
    logic [64:0] s;
    logic        sgn;
    logic        lt;
    logic        eq;
    logic        ov;
    o   = '0;
    w   = 8 << r.vew;
    m   = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    sgn = r.op inside {OP_MIN, OP_MAX, OP_SLT, OP_SLE};
    for (int k = 0; k < `SIMD_ALU_DW / w; k++) begin
      a  = (r.opa >> (k * w)) & m;
      b  = (r.opb >> (k * w)) & m;
      sa = a[w-1] ? (a | ~m) : a;
      sb = b[w-1] ? (b | ~m) : b;
      sh = int'(a[5:0]) % w;
      // lt means b below a in the order of the op
      lt = sgn ? ($signed(sb) < $signed(sa)) : (b < a);
      eq = (a == b);
      ov = 1'b0;
      case (r.op)
        OP_AND:  e = a & b;
        OP_OR:   e = a | b;
        OP_XOR:  e = a ^ b;
        OP_ADD:  e = b + a;
        OP_SUB:  e = b - a;
        OP_RSUB: e = a - b;
        OP_SADDU: begin
          s  = {1'b0, b} + {1'b0, a};
          ov = s > {1'b0, m};
          e  = ov ? m : s[63:0];
        end
        OP_SSUBU: begin
          ov = b < a;
          e  = ov ? '0 : b - a;
        end
        OP_MIN, OP_MINU: e = lt ? b : a;
        OP_MAX, OP_MAXU: e = lt ? a : b;
        OP_SEQ:          e = {63'd0, eq};
        OP_SNE:          e = {63'd0, !eq};
        OP_SLT, OP_SLTU: e = {63'd0, lt};
        OP_SLE, OP_SLEU: e = {63'd0, lt | eq};
        OP_SLL:          e = b << sh;
        OP_SRL:          e = b >> sh;
        default:         e = $signed(sb) >>> sh;
      endcase
      o.res = o.res | ((e & m) << (k * w));
      if (ov) begin
        o.sat = o.sat | strb_t'(((1 << (w / 8)) - 1) << (k * w / 8));
      end
    end
    return o;
  endfunction

  always_ff @(posedge clk_i) begin
    vld_q <= valid_i;
    op_q  <= req_i.op;
    exp_q <= exp_rsp(req_i);
  end

  assign failed = bad_rst | bad_idle | bad_valid | bad_data | bad_sat | bad_nosat;

  //////////////////////////////
  // Assertions
  //////////////////////////////

  a_rst: assert property (@(posedge arst_n_i) !valid_o && rsp_o == '0)
    else begin
      bad_rst = 1'b1;
      $error("outputs not cleared by reset");
    end

  a_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !vld_q |-> !valid_o && rsp_o == '0)
    else begin
      bad_idle = 1'b1;
      $error("output not cleared after an idle cycle");
    end

  a_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i) valid_o == vld_q)
    else begin
      bad_valid = 1'b1;
      $error("valid_o does not follow valid_i by one cycle");
    end

  a_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    vld_q && !(op_q inside {OP_SADDU, OP_SSUBU}) |-> rsp_o.res == exp_q.res)
    else begin
      bad_data = 1'b1;
      $error("result %h, expected %h", $sampled(rsp_o.res), $sampled(exp_q.res));
    end

  a_sat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    vld_q && (op_q inside {OP_SADDU, OP_SSUBU}) |-> rsp_o == exp_q)
    else begin
      bad_sat = 1'b1;
      $error("saturating result %h/%h, expected %h/%h",
             $sampled(rsp_o.res), $sampled(rsp_o.sat),
             $sampled(exp_q.res), $sampled(exp_q.sat));
    end

  a_nosat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    vld_q && !(op_q inside {OP_SADDU, OP_SSUBU}) |-> rsp_o.sat == '0)
    else begin
      bad_nosat = 1'b1;
      $error("saturation flags set for a non-saturating op");
    end

endmodule

// File: tb/simd_alu_tb.sv
`timescale 1ns/100ps

module simd_alu_tb;
  import simd_alu_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int NRAND   = 8;

  logic     clk_i;
  logic     arst_n_i;
  logic     valid_i;
  alu_req_t req_i;
  logic     valid_o;
  alu_rsp_t rsp_o;

  // Overflow, equal, sign bits, zero shift, max shift, unsigned borrow
  elem_t dir_a [6] = '{
    64'hffff_ffff_ffff_ffff, 64'h8001_7ffe_0000_0001, 64'h8080_8080_8080_8080,
    64'h0000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0001
  };
  elem_t dir_b [6] = '{
    64'h0101_0101_0101_0101, 64'h8001_7ffe_0000_0001, 64'h7f7f_7f7f_7f7f_7f7f,
    64'h8421_0fed_cba9_8765, 64'h8000_8000_8000_8000, 64'h0000_0000_0000_0000
  };

  simd_alu dut_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .valid_o  (valid_o),
    .rsp_o    (rsp_o)
  );

  bind simd_alu simd_alu_chk u_chk (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .valid_o  (valid_o),
    .rsp_o    (rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // First assertion failure ends the run
  always @(negedge clk_i) begin
    if (dut_i.u_chk.failed) begin
      $display("*** TEST FAILED ***");
      $display("FAIL %0t: assertion in simd_alu_chk failed", $time);
      $fatal(1, "checker reported a mismatch");
    end
  end

  task automatic send(alu_op_e op, vew_e ew, elem_t a, elem_t b);
    @(posedge clk_i);
    valid_i <= 1'b1;
    req_i   <= '{op: op, vew: ew, opa: a, opb: b};
  endtask

  // Idle cycle with junk operands on the bus
  task automatic idle();
    @(posedge clk_i);
    valid_i   <= 1'b0;
    req_i.opa <= {$urandom, $urandom};
    req_i.opb <= {$urandom, $urandom};
  endtask

  task automatic wait_for_idle(string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (valid_o !== 1'b0 || rsp_o !== '0) begin
      if (n == TIMEOUT) begin
        $display("*** TEST FAILED ***");
        $fatal(1, "Timed out waiting for the DUT outputs to go idle %s", what);
      end
      n++;
      @(negedge clk_i);
    end
  endtask

  initial begin
    alu_op_e op;
    vew_e    ew;
    arst_n_i = 1'b0;
    valid_i  = 1'b0;
    req_i    = '0;
    void'($urandom(32'h1de0_e80b));
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    wait_for_idle("after reset");

    for (int o = 0; o <= int'(OP_SRA); o++) begin
      for (int e = 0; e < 4; e++) begin
        op = alu_op_e'(o);
        ew = vew_e'(e);
        for (int d = 0; d < 6; d++) begin
          send(op, ew, dir_a[d], dir_b[d]);
        end
        for (int r = 0; r < NRAND; r++) begin
          send(op, ew, {$urandom, $urandom}, {$urandom, $urandom});
          if ($urandom_range(3) == 0) begin
            idle();
          end
        end
        idle();
      end
    end

    idle();
    wait_for_idle("at the end of the sweep");
    if (dut_i.u_chk.failed) begin
      $display("*** TEST FAILED ***");
      $display("FAIL %0t: assertion in simd_alu_chk failed", $time);
      $fatal(1, "checker reported a mismatch");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule
